// File: snq_pkg.sv
// snoop queue entry shared types: snoop codes, coherence response layout, FSM state
package snq_pkg;

  // -------------------------------------------------------------------------
  // widths
  // -------------------------------------------------------------------------
  localparam int PA_WIDTH   = 40;
  // queue depth default, also sizes the create payload
  localparam int DEPD_WIDTH = 10;

  typedef logic [PA_WIDTH-1:0] pa_t;
  // 16-byte aligned line address, low 4 bits dropped
  typedef logic [PA_WIDTH-5:0] line_addr_t;

  // -------------------------------------------------------------------------
  // snoop types
  // -------------------------------------------------------------------------
  typedef logic [3:0] snoop_type_t;

  localparam snoop_type_t READ_ONCE     = 4'b0000;
  localparam snoop_type_t READ_SHARED   = 4'b0001;
  localparam snoop_type_t READ_UNIQUE   = 4'b0111;
  localparam snoop_type_t CLEAN_SHARED  = 4'b1000;
  localparam snoop_type_t CLEAN_INVALID = 4'b1001;
  localparam snoop_type_t MAKE_INVALID  = 4'b1101;

  // -------------------------------------------------------------------------
  // coherence response bit positions
  // -------------------------------------------------------------------------
  typedef logic [4:0] cr_resp_t;

  localparam int CR_DATA_TRANSFER = 0;
  localparam int CR_ERROR         = 1;
  localparam int CR_PASS_DIRTY    = 2;
  localparam int CR_IS_SHARED     = 3;
  // not supported, always 0
  localparam int CR_WAS_UNIQUE    = 4;

  // snoop tag FSM, one-hot
  typedef enum logic [4:0] {
    SNPT_IDLE           = 5'b00001,
    SNPT_WAIT_RESP      = 5'b00010,
    SNPT_SDT_REQ        = 5'b00100,
    SNPT_WAIT_SDT_CMPLT = 5'b01000,
    SNPT_WAIT_POP       = 5'b10000
  } snpt_state_e;

  // -------------------------------------------------------------------------
  // payloads
  // -------------------------------------------------------------------------
  typedef struct packed {
    pa_t                   addr;
    snoop_type_t           snp_type;
    logic [DEPD_WIDTH-1:0] depd;
  } snq_create_t;

  typedef struct packed {
    logic valid;
    logic dirty;
    logic share;
    logic way;
  } tag_resp_t;

  // follow-up work for the data/tag step
  typedef struct packed {
    logic need_read_data;
    logic need_chg_tag_s;
    logic need_chg_tag_i;
    logic need_chg_tag;
    logic way;
  } snpdt_req_t;

endpackage

// File: snq_entry_store.sv
// snoop queue entry storage: valid bit, line address, type, dependencies, issued flag
`timescale 1ns/1ns

module snq_entry_store
  import snq_pkg::*;
#(
  parameter int DEPD_WIDTH = snq_pkg::DEPD_WIDTH
)
(
  input  logic                  snqctrlclk,
  input  logic                  cpurst_b,
  input  logic                  snq_create_en,
  input  snq_create_t           snq_create,
  input  logic [DEPD_WIDTH-1:0] snq_depd_remove,
  input  logic                  tag_issue,
  input  logic                  entry_pop,
  output logic                  snq_vld,
  output logic                  snq_rd_tag_rdy,
  output logic                  snq_issued,
  output line_addr_t            snq_addr,
  output snoop_type_t           snq_type
);

  logic [DEPD_WIDTH-1:0] depd_q;
  logic [DEPD_WIDTH-1:0] create_depd;

  // payload depd is sized by the package default
  assign create_depd = DEPD_WIDTH'(snq_create.depd);

  // -------------------------------------------------------------------------
  // valid and issued
  // -------------------------------------------------------------------------
  always_ff @(posedge snqctrlclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      snq_vld <= 1'b0;
    else if (snq_create_en)
      snq_vld <= 1'b1;
    else if (entry_pop)
      snq_vld <= 1'b0;
  end

  always_ff @(posedge snqctrlclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      snq_issued <= 1'b0;
    else if (entry_pop)
      snq_issued <= 1'b0;
    else if (tag_issue)
      snq_issued <= 1'b1;
  end

  // -------------------------------------------------------------------------
  // dependency tracking
  // -------------------------------------------------------------------------
  always_ff @(posedge snqctrlclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      depd_q <= '0;
    else if (snq_create_en)
      depd_q <= create_depd;
    else
      depd_q <= depd_q & ~snq_depd_remove;
  end

  // tag read allowed once every older entry it waits on is gone
  assign snq_rd_tag_rdy = snq_vld && !snq_issued && !(|depd_q);

  // stored snoop type
  always_ff @(posedge snqctrlclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      snq_type <= READ_ONCE;
    else if (snq_create_en)
      snq_type <= snq_create.snp_type;
  end

  // line aligned address
  always_ff @(posedge snqctrlclk)
  begin
    if (snq_create_en)
      snq_addr <= snq_create.addr[PA_WIDTH-1:4];
  end

  // queue must only allocate a free entry
  a_no_create_while_vld : assert property (
    @(posedge snqctrlclk) disable iff (!cpurst_b)
    snq_create_en |-> !snq_vld
  ) else $error("create on a valid snoop queue entry");

endmodule

// File: snq_resp_gen.sv
// snoop response generator: tag response to coherence response and follow-up flags
`timescale 1ns/1ns

module snq_resp_gen
  import snq_pkg::*;
(
  input  logic        snqctrlclk,
  input  logic        cpurst_b,
  input  logic        save_tag_resp,
  input  tag_resp_t   dcache_snq_tag_resp,
  input  logic        st_da_snq_ecc_err,
  input  snoop_type_t snq_type,
  output logic        need_snpdt,
  output cr_resp_t    snq_cr_resp,
  output snpdt_req_t  snq_snpdt_req,
  output logic        snq_tag_req_for_inv
);

  logic       dirty_vld;
  logic       data_transfer;
  logic       pass_dirty;
  logic       is_shared;
  logic       chg_tag_m;
  logic       chg_tag_s;
  logic       chg_tag_i;
  logic       chg_tag_any;
  cr_resp_t   resp_d;
  snpdt_req_t req_d;

  // -------------------------------------------------------------------------
  // response decode
  // -------------------------------------------------------------------------
  // line held in M
  assign dirty_vld = dcache_snq_tag_resp.valid && dcache_snq_tag_resp.dirty;

  // only a dirty line moves data, L2 is inclusive
  assign data_transfer = dirty_vld &&
                         (snq_type inside {READ_SHARED, READ_UNIQUE, READ_ONCE,
                                           CLEAN_INVALID, CLEAN_SHARED});

  // read once leaves the dirty copy here
  assign pass_dirty = dirty_vld &&
                      (snq_type inside {READ_SHARED, READ_UNIQUE,
                                        CLEAN_INVALID, CLEAN_SHARED});

  assign is_shared = dcache_snq_tag_resp.valid &&
                     (snq_type inside {READ_SHARED, READ_ONCE, CLEAN_SHARED});

  always_comb
  begin
    resp_d                   = '0;
    resp_d[CR_DATA_TRANSFER] = data_transfer;
    resp_d[CR_ERROR]         = st_da_snq_ecc_err;
    resp_d[CR_PASS_DIRTY]    = pass_dirty;
    resp_d[CR_IS_SHARED]     = is_shared;
    resp_d[CR_WAS_UNIQUE]    = 1'b0;
  end

  // -------------------------------------------------------------------------
  // follow-up tag change
  // -------------------------------------------------------------------------
  assign snq_tag_req_for_inv = snq_type inside {READ_UNIQUE, CLEAN_INVALID, MAKE_INVALID};

  // M to clean state on clean shared
  assign chg_tag_m = dirty_vld && (snq_type == CLEAN_SHARED);

  // E or M downgrade to S
  assign chg_tag_s = dcache_snq_tag_resp.valid && !dcache_snq_tag_resp.share &&
                     (snq_type inside {CLEAN_SHARED, READ_SHARED});

  assign chg_tag_i   = dcache_snq_tag_resp.valid && snq_tag_req_for_inv;
  assign chg_tag_any = chg_tag_m || chg_tag_s || chg_tag_i;

  // unregistered, steers the FSM out of WAIT_RESP
  assign need_snpdt = data_transfer || chg_tag_any;

  always_comb
  begin
    req_d.need_read_data = data_transfer;
    req_d.need_chg_tag_s = chg_tag_s;
    req_d.need_chg_tag_i = chg_tag_i;
    req_d.need_chg_tag   = chg_tag_any;
    req_d.way            = dcache_snq_tag_resp.way;
  end

  // -------------------------------------------------------------------------
  // capture on tag response
  // -------------------------------------------------------------------------
  always_ff @(posedge snqctrlclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      snq_cr_resp   <= '0;
      snq_snpdt_req <= '0;
    end
    else if (save_tag_resp)
    begin
      snq_cr_resp   <= resp_d;
      snq_snpdt_req <= req_d;
    end
  end

endmodule

// File: snq_tag_fsm.sv
// snoop tag FSM: tag read, data/tag step and response return for one entry
`timescale 1ns/1ns

module snq_tag_fsm
  import snq_pkg::*;
(
  input  logic snqctrlclk,
  input  logic cpurst_b,
  input  logic snq_vld,
  input  logic snq_snoop_tag_start,
  input  logic dcache_snq_snoop_tag_grnt,
  input  logic snq_resp_create_en,
  input  logic need_snpdt,
  input  logic arb_snq_entry_oldest_index,
  input  logic dcache_snq_snpdt_grnt,
  input  logic snpdt_snq_cmplt,
  input  logic biu_snq_cr_resp_acept,
  output logic tag_issue,
  output logic save_tag_resp,
  output logic entry_pop,
  output logic snpt_snpdt_start,
  output logic snq_cr_resp_valid
);

  snpt_state_e state_q;
  snpt_state_e state_d;
  logic        st_idle;
  logic        st_wait_resp;
  logic        st_sdt_req;
  logic        st_wait_pop;

  assign st_idle      = (state_q == SNPT_IDLE);
  assign st_wait_resp = (state_q == SNPT_WAIT_RESP);
  assign st_sdt_req   = (state_q == SNPT_SDT_REQ);
  assign st_wait_pop  = (state_q == SNPT_WAIT_POP);

  // -------------------------------------------------------------------------
  // handshakes
  // -------------------------------------------------------------------------
  // tag read taken in the grant cycle
  assign tag_issue = st_idle && snq_vld && snq_snoop_tag_start && dcache_snq_snoop_tag_grnt;

  assign save_tag_resp = st_wait_resp && snq_resp_create_en;

  // data/tag step and response return go in queue order
  assign snpt_snpdt_start  = st_sdt_req && arb_snq_entry_oldest_index;
  assign snq_cr_resp_valid = st_wait_pop && arb_snq_entry_oldest_index;
  assign entry_pop         = snq_cr_resp_valid && biu_snq_cr_resp_acept;

  // -------------------------------------------------------------------------
  // state register and next state
  // -------------------------------------------------------------------------
  always_ff @(posedge snqctrlclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      state_q <= SNPT_IDLE;
    else
      state_q <= state_d;
  end

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      SNPT_IDLE:
      begin
        if (tag_issue)
          state_d = SNPT_WAIT_RESP;
      end
      SNPT_WAIT_RESP:
      begin
        // skip the data/tag step when nothing needs doing
        if (save_tag_resp)
          state_d = need_snpdt ? SNPT_SDT_REQ : SNPT_WAIT_POP;
      end
      SNPT_SDT_REQ:
      begin
        if (snpt_snpdt_start && dcache_snq_snpdt_grnt)
          state_d = SNPT_WAIT_SDT_CMPLT;
      end
      SNPT_WAIT_SDT_CMPLT:
      begin
        // latency set by the data path
        if (snpdt_snq_cmplt)
          state_d = SNPT_WAIT_POP;
      end
      SNPT_WAIT_POP:
      begin
        if (entry_pop)
          state_d = SNPT_IDLE;
      end
      default:
      begin
        state_d = SNPT_IDLE;
      end
    endcase
  end

  // -------------------------------------------------------------------------
  // checks
  // -------------------------------------------------------------------------
  a_state_onehot : assert property (
    @(posedge snqctrlclk) disable iff (!cpurst_b)
    $onehot(state_q)
  ) else $error("snoop tag FSM state not one-hot");

  // dcache answers only a request that is outstanding
  a_resp_in_wait_resp : assert property (
    @(posedge snqctrlclk) disable iff (!cpurst_b)
    snq_resp_create_en |-> st_wait_resp
  ) else $error("tag response outside WAIT_RESP");

  a_start_while_vld : assert property (
    @(posedge snqctrlclk) disable iff (!cpurst_b)
    snq_snoop_tag_start |-> snq_vld
  ) else $error("tag read start on an invalid entry");

endmodule

// File: snq_entry.sv
// snoop queue entry top: storage, response generator and snoop tag FSM
`timescale 1ns/1ns

module snq_entry
  import snq_pkg::*;
#(
  parameter int DEPD_WIDTH = snq_pkg::DEPD_WIDTH
)
(
  input  logic                  snqctrlclk,
  input  logic                  cpurst_b,
  input  logic                  snq_create_en,
  input  snq_create_t           snq_create,
  input  logic [DEPD_WIDTH-1:0] snq_depd_remove,
  input  logic                  snq_snoop_tag_start,
  input  logic                  dcache_snq_snoop_tag_grnt,
  input  logic                  snq_resp_create_en,
  input  tag_resp_t             dcache_snq_tag_resp,
  input  logic                  st_da_snq_ecc_err,
  input  logic                  arb_snq_entry_oldest_index,
  input  logic                  dcache_snq_snpdt_grnt,
  input  logic                  snpdt_snq_cmplt,
  input  logic                  biu_snq_cr_resp_acept,
  output logic                  snq_vld,
  output logic                  snq_rd_tag_rdy,
  output logic                  snq_issued,
  output line_addr_t            snq_addr,
  output logic                  snq_tag_req_for_inv,
  output logic                  snpt_snpdt_start,
  output snpdt_req_t            snq_snpdt_req,
  output logic                  snq_cr_resp_valid,
  output cr_resp_t              snq_cr_resp
);

  snoop_type_t snq_type;
  logic        tag_issue;
  logic        entry_pop;
  logic        save_tag_resp;
  logic        need_snpdt;

  // -------------------------------------------------------------------------
  // entry fields
  // -------------------------------------------------------------------------
  snq_entry_store #(
    .DEPD_WIDTH (DEPD_WIDTH)
  ) store_i (
    .snqctrlclk      (snqctrlclk),
    .cpurst_b        (cpurst_b),
    .snq_create_en   (snq_create_en),
    .snq_create      (snq_create),
    .snq_depd_remove (snq_depd_remove),
    .tag_issue       (tag_issue),
    .entry_pop       (entry_pop),
    .snq_vld         (snq_vld),
    .snq_rd_tag_rdy  (snq_rd_tag_rdy),
    .snq_issued      (snq_issued),
    .snq_addr        (snq_addr),
    .snq_type        (snq_type)
  );

  // tag response decode
  snq_resp_gen resp_gen_i (
    .snqctrlclk          (snqctrlclk),
    .cpurst_b            (cpurst_b),
    .save_tag_resp       (save_tag_resp),
    .dcache_snq_tag_resp (dcache_snq_tag_resp),
    .st_da_snq_ecc_err   (st_da_snq_ecc_err),
    .snq_type            (snq_type),
    .need_snpdt          (need_snpdt),
    .snq_cr_resp         (snq_cr_resp),
    .snq_snpdt_req       (snq_snpdt_req),
    .snq_tag_req_for_inv (snq_tag_req_for_inv)
  );

  // sequencing
  snq_tag_fsm tag_fsm_i (
    .snqctrlclk                 (snqctrlclk),
    .cpurst_b                   (cpurst_b),
    .snq_vld                    (snq_vld),
    .snq_snoop_tag_start        (snq_snoop_tag_start),
    .dcache_snq_snoop_tag_grnt  (dcache_snq_snoop_tag_grnt),
    .snq_resp_create_en         (snq_resp_create_en),
    .need_snpdt                 (need_snpdt),
    .arb_snq_entry_oldest_index (arb_snq_entry_oldest_index),
    .dcache_snq_snpdt_grnt      (dcache_snq_snpdt_grnt),
    .snpdt_snq_cmplt            (snpdt_snq_cmplt),
    .biu_snq_cr_resp_acept      (biu_snq_cr_resp_acept),
    .tag_issue                  (tag_issue),
    .save_tag_resp              (save_tag_resp),
    .entry_pop                  (entry_pop),
    .snpt_snpdt_start           (snpt_snpdt_start),
    .snq_cr_resp_valid          (snq_cr_resp_valid)
  );

endmodule

// File: tb_snq_entry.sv
// snoop queue entry testbench: random snoops through create, tag read, data/tag step and pop
`timescale 1ns/1ns

module tb_snq_entry
  import snq_pkg::*;
();

  localparam int DEPD_W         = 10;
  localparam int N_TXN          = 200;
  localparam int TIMEOUT_CYCLES = N_TXN * 40 + 100;

  logic              snqctrlclk;
  logic              cpurst_b;
  logic              snq_create_en;
  snq_create_t       snq_create;
  logic [DEPD_W-1:0] snq_depd_remove;
  logic              snq_snoop_tag_start;
  logic              dcache_snq_snoop_tag_grnt;
  logic              snq_resp_create_en;
  tag_resp_t         dcache_snq_tag_resp;
  logic              st_da_snq_ecc_err;
  logic              arb_snq_entry_oldest_index;
  logic              dcache_snq_snpdt_grnt;
  logic              snpdt_snq_cmplt;
  logic              biu_snq_cr_resp_acept;
  logic              snq_vld;
  logic              snq_rd_tag_rdy;
  logic              snq_issued;
  line_addr_t        snq_addr;
  logic              snq_tag_req_for_inv;
  logic              snpt_snpdt_start;
  snpdt_req_t        snq_snpdt_req;
  logic              snq_cr_resp_valid;
  cr_resp_t          snq_cr_resp;

  logic [31:0] lfsr_state;
  int          cycle_cnt = 0;
  int          err_cnt = 0;
  int          test_cnt = 0;
  int          test_fail_cnt = 0;
  string       test_name;

  snq_entry #(
    .DEPD_WIDTH (DEPD_W)
  ) dut_i (
    .snqctrlclk                 (snqctrlclk),
    .cpurst_b                   (cpurst_b),
    .snq_create_en              (snq_create_en),
    .snq_create                 (snq_create),
    .snq_depd_remove            (snq_depd_remove),
    .snq_snoop_tag_start        (snq_snoop_tag_start),
    .dcache_snq_snoop_tag_grnt  (dcache_snq_snoop_tag_grnt),
    .snq_resp_create_en         (snq_resp_create_en),
    .dcache_snq_tag_resp        (dcache_snq_tag_resp),
    .st_da_snq_ecc_err          (st_da_snq_ecc_err),
    .arb_snq_entry_oldest_index (arb_snq_entry_oldest_index),
    .dcache_snq_snpdt_grnt      (dcache_snq_snpdt_grnt),
    .snpdt_snq_cmplt            (snpdt_snq_cmplt),
    .biu_snq_cr_resp_acept      (biu_snq_cr_resp_acept),
    .snq_vld                    (snq_vld),
    .snq_rd_tag_rdy             (snq_rd_tag_rdy),
    .snq_issued                 (snq_issued),
    .snq_addr                   (snq_addr),
    .snq_tag_req_for_inv        (snq_tag_req_for_inv),
    .snpt_snpdt_start           (snpt_snpdt_start),
    .snq_snpdt_req              (snq_snpdt_req),
    .snq_cr_resp_valid          (snq_cr_resp_valid),
    .snq_cr_resp                (snq_cr_resp)
  );

  initial
  begin
    snqctrlclk = 1'b0;
    forever #50 snqctrlclk = ~snqctrlclk;
  end

  // run limit
  always @(posedge snqctrlclk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > TIMEOUT_CYCLES)
    begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // random numbers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one LFSR step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[62:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic snoop_type_t pick_type();
    logic [63:0] k;
    k = rand_bits(3);
    while (k > 5)
      k = rand_bits(3);
    case (k)
      0: return READ_ONCE;
      1: return READ_SHARED;
      2: return READ_UNIQUE;
      3: return CLEAN_SHARED;
      4: return CLEAN_INVALID;
      default: return MAKE_INVALID;
    endcase
  endfunction

  // --------------------------------------------------------------------------
  // reference model
  // --------------------------------------------------------------------------
  task automatic model_snoop(input snoop_type_t t, input tag_resp_t tr, input logic ecc,
                             output cr_resp_t resp, output snpdt_req_t req,
                             output logic inv_kind, output logic need_step);
    logic dt_kind;
    logic pd_kind;
    logic sh_kind;
    logic s_kind;
    logic m_kind;
    logic hit_dirty;
    // per type: data, pass dirty, shared, to S, clean M, invalidate
    case (t)
      READ_ONCE:     {dt_kind, pd_kind, sh_kind, s_kind, m_kind, inv_kind} = 6'b101000;
      READ_SHARED:   {dt_kind, pd_kind, sh_kind, s_kind, m_kind, inv_kind} = 6'b111100;
      READ_UNIQUE:   {dt_kind, pd_kind, sh_kind, s_kind, m_kind, inv_kind} = 6'b110001;
      CLEAN_SHARED:  {dt_kind, pd_kind, sh_kind, s_kind, m_kind, inv_kind} = 6'b111110;
      CLEAN_INVALID: {dt_kind, pd_kind, sh_kind, s_kind, m_kind, inv_kind} = 6'b110001;
      default:       {dt_kind, pd_kind, sh_kind, s_kind, m_kind, inv_kind} = 6'b000001;
    endcase
    hit_dirty          = tr.valid & tr.dirty;
    resp               = {1'b0, sh_kind & tr.valid, pd_kind & hit_dirty, ecc,
                          dt_kind & hit_dirty};
    req.need_read_data = dt_kind & hit_dirty;
    req.need_chg_tag_s = s_kind & tr.valid & ~tr.share;
    req.need_chg_tag_i = inv_kind & tr.valid;
    req.need_chg_tag   = (m_kind & hit_dirty) | req.need_chg_tag_s | req.need_chg_tag_i;
    req.way            = tr.way;
    need_step          = req.need_read_data | req.need_chg_tag;
  endtask

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------
  // inputs change 10 ns after the edge, outputs are read there too
  task automatic step();
    @(posedge snqctrlclk);
    #10;
  endtask

  task automatic compare_value(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
    if (exp !== act)
    begin
      err_cnt = err_cnt + 1;
      $display("[FAIL] %s %s: expected %0h, actual %0h", test_name, what, exp, act);
    end
  endtask

  task automatic report_test(input int err_before);
    test_cnt = test_cnt + 1;
    if (err_cnt == err_before)
      $display("test %s: ok", test_name);
    else
    begin
      test_fail_cnt = test_fail_cnt + 1;
      $display("test %s: %0d mismatches", test_name, err_cnt - err_before);
    end
  endtask

  task automatic check_reset();
    int err_before;
    err_before = err_cnt;
    test_name  = "reset";
    step();
    compare_value("vld", 0, snq_vld);
    compare_value("rd_tag_rdy", 0, snq_rd_tag_rdy);
    compare_value("issued", 0, snq_issued);
    compare_value("snpdt_start", 0, snpt_snpdt_start);
    compare_value("cr_resp_valid", 0, snq_cr_resp_valid);
    compare_value("cr_resp", 0, snq_cr_resp);
    compare_value("snpdt_req", 0, snq_snpdt_req);
    report_test(err_before);
  endtask

  // --------------------------------------------------------------------------
  // one snoop from create to pop
  // --------------------------------------------------------------------------
  task automatic run_txn(input int n);
    snoop_type_t       t;
    logic [63:0]       rnd;
    pa_t               addr;
    logic [DEPD_W-1:0] depd;
    logic [DEPD_W-1:0] rmv;
    tag_resp_t         tr;
    logic              ecc;
    cr_resp_t          exp_resp;
    snpdt_req_t        exp_req;
    logic              exp_inv;
    logic              need_step;
    int                err_before;
    int                round;
    err_before = err_cnt;
    t          = pick_type();
    test_name  = $sformatf("txn%0d_type%b", n, t);
    rnd        = rand_bits(40);
    addr       = rnd[39:0];
    rnd        = rand_bits(DEPD_W);
    depd       = rnd[DEPD_W-1:0];
    rnd        = rand_bits(5);
    tr         = rnd[3:0];
    ecc        = rnd[4];
    model_snoop(t, tr, ecc, exp_resp, exp_req, exp_inv, need_step);

    // create
    snq_create.addr     = addr;
    snq_create.snp_type = t;
    snq_create.depd     = depd;
    snq_create_en       = 1'b1;
    step();
    snq_create_en = 1'b0;
    compare_value("vld after create", 1, snq_vld);
    compare_value("addr", addr[39:4], snq_addr);
    compare_value("tag_req_for_inv", exp_inv, snq_tag_req_for_inv);

    // dependencies drain, all cleared by the fourth round
    round = 0;
    while (depd != '0)
    begin
      compare_value("rdy with dependencies", 0, snq_rd_tag_rdy);
      rnd             = rand_bits(DEPD_W);
      rmv             = (round == 3) ? '1 : rnd[DEPD_W-1:0];
      snq_depd_remove = rmv;
      step();
      snq_depd_remove = '0;
      depd            = depd & ~rmv;
      round           = round + 1;
    end
    compare_value("rdy", 1, snq_rd_tag_rdy);

    // tag read under delayed grant
    snq_snoop_tag_start = 1'b1;
    repeat (rand_bits(3))
    begin
      step();
      compare_value("issued before grant", 0, snq_issued);
    end
    dcache_snq_snoop_tag_grnt = 1'b1;
    step();
    snq_snoop_tag_start       = 1'b0;
    dcache_snq_snoop_tag_grnt = 1'b0;
    compare_value("issued", 1, snq_issued);
    compare_value("rdy after issue", 0, snq_rd_tag_rdy);

    // tag response
    dcache_snq_tag_resp = tr;
    st_da_snq_ecc_err   = ecc;
    snq_resp_create_en  = 1'b1;
    step();
    snq_resp_create_en  = 1'b0;
    dcache_snq_tag_resp = '0;
    st_da_snq_ecc_err   = 1'b0;
    compare_value("cr_resp", exp_resp, snq_cr_resp);
    compare_value("snpdt_req", exp_req, snq_snpdt_req);
    compare_value("snpdt_start not oldest", 0, snpt_snpdt_start);
    compare_value("cr_resp_valid not oldest", 0, snq_cr_resp_valid);

    if (need_step)
    begin
      repeat (rand_bits(3))
      begin
        step();
        compare_value("snpdt_start not oldest", 0, snpt_snpdt_start);
      end
      // oldest without grant at least one cycle
      arb_snq_entry_oldest_index = 1'b1;
      repeat (rand_bits(3) + 1)
      begin
        step();
        compare_value("snpdt_start oldest", 1, snpt_snpdt_start);
        compare_value("cr_resp_valid in step", 0, snq_cr_resp_valid);
      end
      dcache_snq_snpdt_grnt = 1'b1;
      step();
      dcache_snq_snpdt_grnt = 1'b0;
      compare_value("snpdt_start after grant", 0, snpt_snpdt_start);
      repeat (rand_bits(3))
      begin
        rnd                        = rand_bits(1);
        arb_snq_entry_oldest_index = rnd[0];
        step();
        compare_value("snpdt_start wait cmplt", 0, snpt_snpdt_start);
        compare_value("cr_resp_valid before cmplt", 0, snq_cr_resp_valid);
      end
      arb_snq_entry_oldest_index = 1'b0;
      snpdt_snq_cmplt            = 1'b1;
      step();
      snpdt_snq_cmplt = 1'b0;
    end

    // return and pop
    repeat (rand_bits(3))
    begin
      step();
      compare_value("cr_resp_valid not oldest", 0, snq_cr_resp_valid);
    end
    arb_snq_entry_oldest_index = 1'b1;
    repeat (rand_bits(3) + 1)
    begin
      step();
      compare_value("cr_resp_valid", 1, snq_cr_resp_valid);
      compare_value("cr_resp held", exp_resp, snq_cr_resp);
      compare_value("snpdt_start in pop", 0, snpt_snpdt_start);
    end
    biu_snq_cr_resp_acept = 1'b1;
    step();
    biu_snq_cr_resp_acept      = 1'b0;
    arb_snq_entry_oldest_index = 1'b0;
    compare_value("vld after pop", 0, snq_vld);
    compare_value("issued after pop", 0, snq_issued);
    compare_value("cr_resp_valid after pop", 0, snq_cr_resp_valid);
    report_test(err_before);
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------
  initial
  begin
    lfsr_state                 = 32'hdf29_c7ba;
    cpurst_b                   = 1'b0;
    snq_create_en              = 1'b0;
    snq_create                 = '0;
    snq_depd_remove            = '0;
    snq_snoop_tag_start        = 1'b0;
    dcache_snq_snoop_tag_grnt  = 1'b0;
    snq_resp_create_en         = 1'b0;
    dcache_snq_tag_resp        = '0;
    st_da_snq_ecc_err          = 1'b0;
    arb_snq_entry_oldest_index = 1'b0;
    dcache_snq_snpdt_grnt      = 1'b0;
    snpdt_snq_cmplt            = 1'b0;
    biu_snq_cr_resp_acept      = 1'b0;
    repeat (2) @(posedge snqctrlclk);
    #10;
    cpurst_b = 1'b1;
    check_reset();
    for (int i = 0; i < N_TXN; i++)
      run_txn(i);
    $display("summary: %0d tests, %0d with mismatches, %0d mismatches in total",
             test_cnt, test_fail_cnt, err_cnt);
    if (err_cnt == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: src.f
snq_pkg.sv
snq_entry_store.sv
snq_resp_gen.sv
snq_tag_fsm.sv
snq_entry.sv
tb_snq_entry.sv

// File: Bender.yml
package:
  name: snq_entry

sources:
  - snq_pkg.sv
  - snq_entry_store.sv
  - snq_resp_gen.sv
  - snq_tag_fsm.sv
  - snq_entry.sv
  - target: test
    files:
      - tb_snq_entry.sv
